//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_RESET_PC 32'h8000_0000

// ----------------------------------------------------------
// Opcodes
`define RV_OP_IMM 7'b0010011
`define RV_OP_REG 7'b0110011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL 7'b1101111
`define RV_OP_JALR 7'b1100111
`define RV_OP_LUI 7'b0110111
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_SYSTEM 7'b1110011

`define RV_EBREAK_IMM 12'h001

// ----------------------------------------------------------
// funct3 codes
`define RV_F3_SR 3'b101 // Shift right, funct7 bit 5 picks SRA
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001
`define RV_F3_BLT 3'b100
`define RV_F3_BGE 3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111
`define RV_F3_BYTE 3'b000
`define RV_F3_HALF 3'b001
`define RV_F3_WORD 3'b010
`define RV_F3_BYTE_U 3'b100
`define RV_F3_HALF_U 3'b101

// ----------------------------------------------------------
// ALU codes, low half follows {funct7[5], funct3}
`define RV_ALU_ADD 4'b0000
`define RV_ALU_SLL 4'b0001
`define RV_ALU_SLT 4'b0010
`define RV_ALU_SLTU 4'b0011
`define RV_ALU_XOR 4'b0100
`define RV_ALU_SRL 4'b0101
`define RV_ALU_OR 4'b0110
`define RV_ALU_AND 4'b0111
`define RV_ALU_SUB 4'b1000
`define RV_ALU_SRA 4'b1101
`define RV_ALU_EQ 4'b1001 // Branch compares fill the free codes
`define RV_ALU_NE 4'b1010
`define RV_ALU_LT 4'b1011
`define RV_ALU_GE 4'b1100
`define RV_ALU_LTU 4'b1110
`define RV_ALU_GEU 4'b1111

// ----------------------------------------------------------
// Memory access kinds
`define RV_MEM_RD_NONE 3'd0
`define RV_MEM_RD_B 3'd1
`define RV_MEM_RD_H 3'd2
`define RV_MEM_RD_W 3'd3
`define RV_MEM_RD_BU 3'd4
`define RV_MEM_RD_HU 3'd5
`define RV_MEM_WR_NONE 2'd0
`define RV_MEM_WR_B 2'd1
`define RV_MEM_WR_H 2'd2
`define RV_MEM_WR_W 2'd3

`endif

//--- rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [2:0] mem_rd_t;
	typedef logic [1:0] mem_wr_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_pkt_t;

	// Decode to execute bundle
	typedef struct packed {
		word_t pc;
		word_t src1; // ALU operand A, already forwarded
		word_t src2; // Operand B or immediate
		word_t store_data;
		word_t imm;
		reg_idx_t rd;
		logic reg_write;
		alu_op_t alu_op;
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		mem_rd_t mem_rd;
		mem_wr_t mem_wr;
		logic is_ebreak;
	} dec_pkt_t;

	typedef struct packed {
		word_t pc;
		word_t result; // ALU value, address or link
		word_t store_data;
		reg_idx_t rd;
		logic reg_write;
		mem_rd_t mem_rd;
		mem_wr_t mem_wr;
		logic is_ebreak;
	} exe_pkt_t;

	typedef struct packed {
		word_t pc;
		reg_idx_t rd;
		logic reg_write;
		word_t data;
		logic is_ebreak;
	} retire_t;

	// One older instruction as seen from decode
	typedef struct packed {
		logic valid; // Writes a register
		reg_idx_t rd;
		word_t data;
		logic data_ok; // Data is final
	} fwd_t;

endpackage

//--- rv_fetch.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch (
	input logic clk,
	input logic rst_n,
	input logic redirect,
	input rv_pkg::word_t redirect_pc,
	input logic halt,
	output rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_data,
	output logic fetch_valid,
	output rv_pkg::fetch_pkt_t fetch_pkt,
	input logic decode_ready
);
	import rv_pkg::*;

	word_t pc;
	logic take;

	assign imem_addr = pc;
	assign take = !fetch_valid || decode_ready; // Slot empty or being drained

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
			fetch_valid <= 1'b0;
		end else if (redirect) begin
			pc <= redirect_pc;
			fetch_valid <= 1'b0; // Drop the wrong-path packet
		end else if (halt) begin
			fetch_valid <= 1'b0;
		end else if (take) begin
			pc <= pc + 32'd4;
			fetch_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			fetch_pkt.pc <= pc;
			fetch_pkt.inst <= imem_data;
		end
	end

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
	input logic clk,
	input logic rst_n,
	input logic fetch_valid,
	input rv_pkg::fetch_pkt_t fetch_pkt,
	output logic decode_ready,
	output rv_pkg::reg_idx_t rs1_idx,
	output rv_pkg::reg_idx_t rs2_idx,
	input rv_pkg::word_t rs1_data,
	input rv_pkg::word_t rs2_data,
	input rv_pkg::fwd_t fwd_exe,
	input rv_pkg::fwd_t fwd_mem,
	input rv_pkg::fwd_t fwd_wb,
	input logic flush,
	output logic dec_valid,
	output rv_pkg::dec_pkt_t dec_pkt
);
	import rv_pkg::*;

	word_t inst;
	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t rs1_val;
	word_t rs2_val;
	logic use_rs1;
	logic use_rs2;
	logic stall;
	logic halt_seen;
	logic halt_now;
	dec_pkt_t pkt;

	assign inst = fetch_pkt.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// ----------------------------------------------------------
	// Forwarding, execute first, then memory, then writeback
	function automatic logic fwd_hit(fwd_t f, reg_idx_t idx);
		return f.valid && (f.rd == idx) && (idx != '0);
	endfunction

	function automatic word_t fwd_pick(reg_idx_t idx, word_t rf_data);
		if (fwd_hit(fwd_exe, idx))
			return fwd_exe.data;
		else if (fwd_hit(fwd_mem, idx))
			return fwd_mem.data;
		else if (fwd_hit(fwd_wb, idx))
			return fwd_wb.data;
		return rf_data;
	endfunction

	function automatic logic fwd_wait(reg_idx_t idx);
		if (fwd_hit(fwd_exe, idx))
			return !fwd_exe.data_ok; // Load still in execute
		else if (fwd_hit(fwd_mem, idx))
			return !fwd_mem.data_ok;
		else if (fwd_hit(fwd_wb, idx))
			return !fwd_wb.data_ok;
		return 1'b0;
	endfunction

	always_comb begin
		rs1_val = fwd_pick(rs1_idx, rs1_data);
		rs2_val = fwd_pick(rs2_idx, rs2_data);
		stall = (use_rs1 && fwd_wait(rs1_idx)) || (use_rs2 && fwd_wait(rs2_idx));
	end

	// ----------------------------------------------------------
	// Field decode
	always_comb begin
		pkt = '0;
		pkt.pc = fetch_pkt.pc;
		pkt.rd = inst[11:7];
		pkt.src1 = rs1_val;
		pkt.src2 = rs2_val;
		pkt.store_data = rs2_val;
		pkt.alu_op = `RV_ALU_ADD;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			`RV_OP_IMM: begin
				pkt.imm = imm_i;
				pkt.src2 = imm_i;
				pkt.reg_write = 1'b1;
				pkt.alu_op = {(funct3 == `RV_F3_SR) ? inst[30] : 1'b0, funct3};
				use_rs1 = 1'b1;
			end
			`RV_OP_REG: begin
				pkt.reg_write = 1'b1;
				pkt.alu_op = {inst[30], funct3};
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			`RV_OP_LOAD: begin
				pkt.imm = imm_i;
				pkt.src2 = imm_i;
				use_rs1 = 1'b1;
				case (funct3)
					`RV_F3_BYTE: pkt.mem_rd = `RV_MEM_RD_B;
					`RV_F3_HALF: pkt.mem_rd = `RV_MEM_RD_H;
					`RV_F3_WORD: pkt.mem_rd = `RV_MEM_RD_W;
					`RV_F3_BYTE_U: pkt.mem_rd = `RV_MEM_RD_BU;
					`RV_F3_HALF_U: pkt.mem_rd = `RV_MEM_RD_HU;
					default: pkt.mem_rd = `RV_MEM_RD_NONE;
				endcase
				pkt.reg_write = (pkt.mem_rd != `RV_MEM_RD_NONE); // Unknown width is a no-op
			end
			`RV_OP_STORE: begin
				pkt.imm = imm_s;
				pkt.src2 = imm_s;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (funct3)
					`RV_F3_BYTE: pkt.mem_wr = `RV_MEM_WR_B;
					`RV_F3_HALF: pkt.mem_wr = `RV_MEM_WR_H;
					`RV_F3_WORD: pkt.mem_wr = `RV_MEM_WR_W;
					default: pkt.mem_wr = `RV_MEM_WR_NONE;
				endcase
			end
			`RV_OP_BRANCH: begin
				pkt.imm = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				pkt.is_branch = 1'b1;
				case (funct3)
					`RV_F3_BEQ: pkt.alu_op = `RV_ALU_EQ;
					`RV_F3_BNE: pkt.alu_op = `RV_ALU_NE;
					`RV_F3_BLT: pkt.alu_op = `RV_ALU_LT;
					`RV_F3_BGE: pkt.alu_op = `RV_ALU_GE;
					`RV_F3_BLTU: pkt.alu_op = `RV_ALU_LTU;
					`RV_F3_BGEU: pkt.alu_op = `RV_ALU_GEU;
					default: pkt.is_branch = 1'b0;
				endcase
			end
			`RV_OP_JAL: begin
				pkt.imm = imm_j;
				pkt.src1 = fetch_pkt.pc;
				pkt.src2 = imm_j;
				pkt.is_jal = 1'b1;
				pkt.reg_write = 1'b1;
			end
			`RV_OP_JALR: begin
				pkt.imm = imm_i;
				pkt.src2 = imm_i;
				pkt.is_jalr = 1'b1;
				pkt.reg_write = 1'b1;
				use_rs1 = 1'b1;
			end
			`RV_OP_LUI: begin
				pkt.imm = imm_u;
				pkt.src1 = '0;
				pkt.src2 = imm_u;
				pkt.reg_write = 1'b1;
			end
			`RV_OP_AUIPC: begin
				pkt.imm = imm_u;
				pkt.src1 = fetch_pkt.pc;
				pkt.src2 = imm_u;
				pkt.reg_write = 1'b1;
			end
			`RV_OP_SYSTEM: begin
				pkt.is_ebreak = (funct3 == 3'b000) && (inst[31:20] == `RV_EBREAK_IMM);
			end
			default: begin
			end
		endcase
	end

	// An EBREAK in execute blocks every younger instruction
	assign halt_now = halt_seen || (dec_valid && dec_pkt.is_ebreak);
	assign decode_ready = !stall && !halt_now;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			dec_valid <= fetch_valid && decode_ready && !flush; // Bubble on stall or flush
			halt_seen <= halt_now;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid && decode_ready)
			dec_pkt <= pkt;
	end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
	input logic clk,
	input logic rst_n,
	input logic dec_valid,
	input rv_pkg::dec_pkt_t dec_pkt,
	output rv_pkg::fwd_t fwd_exe,
	output logic redirect,
	output rv_pkg::word_t redirect_pc,
	output logic exe_valid,
	output rv_pkg::exe_pkt_t exe_pkt
);
	import rv_pkg::*;

	word_t a;
	word_t b;
	word_t sum;
	word_t alu;
	word_t result;
	logic cmp;
	logic is_jump;

	assign a = dec_pkt.src1;
	assign b = dec_pkt.src2;
	assign sum = a + b;
	assign is_jump = dec_pkt.is_jal || dec_pkt.is_jalr;

	always_comb begin
		case (dec_pkt.alu_op)
			`RV_ALU_EQ: cmp = (a == b);
			`RV_ALU_NE: cmp = (a != b);
			`RV_ALU_LT: cmp = ($signed(a) < $signed(b));
			`RV_ALU_GE: cmp = ($signed(a) >= $signed(b));
			`RV_ALU_LTU: cmp = (a < b);
			`RV_ALU_GEU: cmp = (a >= b);
			default: cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (dec_pkt.alu_op)
			`RV_ALU_ADD: alu = sum;
			`RV_ALU_SUB: alu = a - b;
			`RV_ALU_SLL: alu = a << b[4:0];
			`RV_ALU_SLT: alu = {31'b0, $signed(a) < $signed(b)};
			`RV_ALU_SLTU: alu = {31'b0, a < b};
			`RV_ALU_XOR: alu = a ^ b;
			`RV_ALU_SRL: alu = a >> b[4:0];
			`RV_ALU_SRA: alu = $signed(a) >>> b[4:0];
			`RV_ALU_OR: alu = a | b;
			`RV_ALU_AND: alu = a & b;
			default: alu = {31'b0, cmp}; // Compare codes
		endcase
	end

	assign result = is_jump ? dec_pkt.pc + 32'd4 : alu; // Link address for jumps

	// ----------------------------------------------------------
	// Branch and jump resolution
	assign redirect = dec_valid && ((dec_pkt.is_branch && cmp) || is_jump);
	assign redirect_pc = dec_pkt.is_jalr ? {sum[31:1], 1'b0} : dec_pkt.pc + dec_pkt.imm;

	assign fwd_exe.valid = dec_valid && dec_pkt.reg_write;
	assign fwd_exe.rd = dec_pkt.rd;
	assign fwd_exe.data = result;
	assign fwd_exe.data_ok = (dec_pkt.mem_rd == `RV_MEM_RD_NONE); // Load data not here yet

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		exe_pkt.pc <= dec_pkt.pc;
		exe_pkt.result <= result;
		exe_pkt.store_data <= dec_pkt.store_data;
		exe_pkt.rd <= dec_pkt.rd;
		exe_pkt.reg_write <= dec_pkt.reg_write;
		exe_pkt.mem_rd <= dec_pkt.mem_rd;
		exe_pkt.mem_wr <= dec_pkt.mem_wr;
		exe_pkt.is_ebreak <= dec_pkt.is_ebreak;
	end

endmodule

//--- rv_memory.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_memory (
	input logic clk,
	input logic rst_n,
	input logic exe_valid,
	input rv_pkg::exe_pkt_t exe_pkt,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	output logic [3:0] dmem_wstrb,
	output logic dmem_write,
	output logic dmem_read,
	input rv_pkg::word_t dmem_rdata,
	output rv_pkg::fwd_t fwd_mem,
	output logic wb_valid,
	output rv_pkg::retire_t wb_pkt
);
	import rv_pkg::*;

	word_t addr;
	logic [4:0] lane_shift;
	word_t rdata_sh;
	word_t wb_data;

	assign addr = exe_pkt.result;
	assign lane_shift = {addr[1:0], 3'b000}; // Byte offset in bits
	assign dmem_addr = {addr[31:2], 2'b00};
	assign dmem_wdata = exe_pkt.store_data << lane_shift;
	assign dmem_write = exe_valid && (exe_pkt.mem_wr != `RV_MEM_WR_NONE);
	assign dmem_read = exe_valid && (exe_pkt.mem_rd != `RV_MEM_RD_NONE);

	always_comb begin
		case (exe_pkt.mem_wr)
			`RV_MEM_WR_B: dmem_wstrb = 4'b0001 << addr[1:0];
			`RV_MEM_WR_H: dmem_wstrb = 4'b0011 << addr[1:0];
			`RV_MEM_WR_W: dmem_wstrb = 4'b1111;
			default: dmem_wstrb = 4'b0000;
		endcase
	end

	// ----------------------------------------------------------
	// Load lane select and extension
	assign rdata_sh = dmem_rdata >> lane_shift;

	always_comb begin
		case (exe_pkt.mem_rd)
			`RV_MEM_RD_B: wb_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
			`RV_MEM_RD_H: wb_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
			`RV_MEM_RD_W: wb_data = dmem_rdata;
			`RV_MEM_RD_BU: wb_data = {24'b0, rdata_sh[7:0]};
			`RV_MEM_RD_HU: wb_data = {16'b0, rdata_sh[15:0]};
			default: wb_data = exe_pkt.result; // Not a load
		endcase
	end

	assign fwd_mem.valid = exe_valid && exe_pkt.reg_write;
	assign fwd_mem.rd = exe_pkt.rd;
	assign fwd_mem.data = wb_data;
	assign fwd_mem.data_ok = 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= exe_valid;
	end

	always_ff @(posedge clk) begin
		wb_pkt.pc <= exe_pkt.pc;
		wb_pkt.rd <= exe_pkt.rd;
		wb_pkt.reg_write <= exe_pkt.reg_write;
		wb_pkt.data <= wb_data;
		wb_pkt.is_ebreak <= exe_pkt.is_ebreak;
	end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic rst_n,
	input logic wb_valid,
	input rv_pkg::retire_t wb_pkt,
	input rv_pkg::reg_idx_t rs1_idx,
	input rv_pkg::reg_idx_t rs2_idx,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data,
	output rv_pkg::fwd_t fwd_wb,
	output logic halted
);
	import rv_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
			halted <= 1'b0;
		end else begin
			if (wb_valid && wb_pkt.reg_write && (wb_pkt.rd != '0))
				regs[wb_pkt.rd] <= wb_pkt.data;
			if (wb_valid && wb_pkt.is_ebreak)
				halted <= 1'b1; // Sticky until reset
		end
	end

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	// Write in flight, not yet visible on the read ports
	assign fwd_wb.valid = wb_valid && wb_pkt.reg_write;
	assign fwd_wb.rd = wb_pkt.rd;
	assign fwd_wb.data = wb_pkt.data;
	assign fwd_wb.data_ok = 1'b1;

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input logic clk,
	input logic rst_n,
	output rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_data,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	output logic [3:0] dmem_wstrb,
	output logic dmem_write,
	output logic dmem_read,
	input rv_pkg::word_t dmem_rdata,
	output logic retire_valid,
	output rv_pkg::retire_t retire,
	output logic halted
);
	import rv_pkg::*;

	logic fetch_valid;
	fetch_pkt_t fetch_pkt;
	logic decode_ready;
	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	word_t rs1_data;
	word_t rs2_data;
	fwd_t fwd_exe;
	fwd_t fwd_mem;
	fwd_t fwd_wb;
	logic redirect;
	word_t redirect_pc;
	logic dec_valid;
	dec_pkt_t dec_pkt;
	logic exe_valid;
	exe_pkt_t exe_pkt;
	logic wb_valid;
	retire_t wb_pkt;

	assign retire = wb_pkt;
	assign retire_valid = wb_valid;

	// ----------------------------------------------------------
	// Stages, matching port names connect by name
	rv_fetch i_rv_fetch (
		.halt(halted),
		.*
	);

	rv_decode i_rv_decode (
		.flush(redirect), // Taken branch or jump kills the younger packet
		.*
	);

	rv_execute i_rv_execute (.*);

	rv_memory i_rv_memory (.*);

	rv_regfile i_rv_regfile (.*);

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;
	import rv_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 64;
	localparam int JALR_AT = 100; // AUIPC x15, then JALR over one word
	localparam int TIMEOUT_CYCLES = PROG_LEN * 6 + 100;
	localparam word_t DATA_BASE = 32'h0001_0000;

	logic clk;
	logic rst_n;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic [3:0] dmem_wstrb;
	logic dmem_write;
	logic dmem_read;
	word_t dmem_rdata;
	logic retire_valid;
	retire_t retire;
	logic halted;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	word_t model_mem [DMEM_WORDS];
	word_t model_regs [32];
	logic [31:0] rng_state;
	int cycles;
	int ret_count;
	int st_count;
	int ld_count;

	// Expected retirements, stores and loads, in program order
	word_t exp_pc [$];
	logic exp_we [$];
	reg_idx_t exp_rd [$];
	word_t exp_data [$];
	logic exp_brk [$];
	word_t st_addr [$];
	logic [3:0] st_strb [$];
	word_t st_data [$];
	word_t ld_addr [$];

	rv_core i_rv_core (.*);

	always #5 clk = ~clk;

	// ----------------------------------------------------------
	// Failure reporting
	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
			abort_run("A checked value did not match the model");
		end
	endtask

	// ----------------------------------------------------------
	// Random numbers and instruction encoding
	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int unsigned rand_below(int unsigned n);
		return rand_word() % n;
	endfunction

	function automatic word_t itype_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t rtype_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic word_t stype_word(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t btype_word(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic word_t utype_word(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic word_t jtype_word(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic word_t nop_word();
		return itype_word(12'd0, 5'd0, 3'b000, 5'd0, `RV_OP_IMM);
	endfunction

	function automatic word_t ebreak_word();
		return itype_word(`RV_EBREAK_IMM, 5'd0, 3'b000, 5'd0, `RV_OP_SYSTEM);
	endfunction

	function automatic reg_idx_t pick_source(reg_idx_t last_rd);
		return rand_below(2) ? last_rd : reg_idx_t'(rand_below(16)); // Favor dependencies
	endfunction

	function automatic logic [11:0] align_offset(logic [11:0] off, logic [2:0] f3);
		case (f3[1:0])
			2'b10: return off & 12'hffc;
			2'b01: return off & 12'hffe;
			default: return off;
		endcase
	endfunction

	// ----------------------------------------------------------
	// Program generator
	task automatic build_program();
		int i;
		int kind;
		int k;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t base;
		reg_idx_t last_rd;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [6:0] f7;
		for (i = 0; i < IMEM_WORDS; i++)
			imem[i] = nop_word();
		imem[0] = utype_word(DATA_BASE[31:12], 5'd1, `RV_OP_LUI);
		imem[1] = itype_word(12'd0, 5'd1, 3'b000, 5'd1, `RV_OP_IMM);
		imem[2] = utype_word(DATA_BASE[31:12], 5'd2, `RV_OP_LUI);
		imem[3] = itype_word(12'd128, 5'd2, 3'b000, 5'd2, `RV_OP_IMM); // Upper half of the window
		last_rd = 5'd2;
		for (i = 4; i < PROG_LEN - 1; i++) begin
			rd = 5'd3 + reg_idx_t'(rand_below(12)); // x3 to x14, bases stay intact
			rs1 = pick_source(last_rd);
			rs2 = pick_source(last_rd);
			base = rand_below(2) ? 5'd1 : 5'd2;
			imm = 12'(rand_below(128));
			k = 1 + rand_below(8);
			kind = rand_below(16);
			if ((kind == 13 || kind == 14) &&
					((i >= JALR_AT - 9 && i <= JALR_AT + 3) || i >= PROG_LEN - 10))
				kind = 0; // No jump may land inside the JALR sequence
			if (i == JALR_AT) begin
				imem[i] = utype_word(20'd0, 5'd15, `RV_OP_AUIPC);
			end else if (i == JALR_AT + 1) begin
				imem[i] = itype_word(12'd12, 5'd15, 3'b000, rd, `RV_OP_JALR);
			end else if (i == JALR_AT + 2) begin
				imem[i] = itype_word(12'h7ff, rs1, 3'b000, rd, `RV_OP_IMM); // Jumped over
			end else begin
				case (kind)
					0, 1, 2, 3, 4: begin
						f3 = 3'(rand_below(8));
						imm = 12'(rand_below(4096));
						if (f3 == 3'b001)
							imm = {7'b0, imm[4:0]};
						else if (f3 == 3'b101)
							imm = {1'b0, imm[10], 5'b0, imm[4:0]}; // SRLI or SRAI
						imem[i] = itype_word(imm, rs1, f3, rd, `RV_OP_IMM);
					end
					5, 6, 7, 8: begin
						f3 = 3'(rand_below(8));
						f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) ?
							7'b0100000 : 7'b0000000;
						imem[i] = rtype_word(f7, rs2, rs1, f3, rd);
					end
					9: imem[i] = utype_word(20'(rand_word()), rd, `RV_OP_LUI);
					10: imem[i] = utype_word(20'(rand_word()), rd, `RV_OP_AUIPC);
					11, 15: begin
						case (rand_below(5))
							0: f3 = `RV_F3_BYTE;
							1: f3 = `RV_F3_HALF;
							2: f3 = `RV_F3_WORD;
							3: f3 = `RV_F3_BYTE_U;
							default: f3 = `RV_F3_HALF_U;
						endcase
						imem[i] = itype_word(align_offset(imm, f3), base, f3, rd, `RV_OP_LOAD);
					end
					12: begin
						f3 = 3'(rand_below(3));
						imem[i] = stype_word(align_offset(imm, f3), rs2, base, f3);
					end
					13: begin
						case (rand_below(6))
							0: f3 = `RV_F3_BEQ;
							1: f3 = `RV_F3_BNE;
							2: f3 = `RV_F3_BLT;
							3: f3 = `RV_F3_BGE;
							4: f3 = `RV_F3_BLTU;
							default: f3 = `RV_F3_BGEU;
						endcase
						imem[i] = btype_word(13'(4 * k), rs2, rs1, f3);
					end
					default: imem[i] = jtype_word(21'(4 * k), rand_below(2) ? 5'd0 : rd);
				endcase
			end
			last_rd = rd;
		end
		imem[PROG_LEN - 1] = ebreak_word();
	endtask

	// ----------------------------------------------------------
	// Instruction-set model
	function automatic word_t fill_word(word_t addr);
		return (addr ^ 32'h6b2f_c3a1) * 32'h0100_0193;
	endfunction

	function automatic word_t imem_lookup(word_t addr);
		word_t off;
		off = addr - `RV_RESET_PC;
		if (off < IMEM_WORDS * 4)
			return imem[off[9:2]];
		return nop_word();
	endfunction

	function automatic word_t dmem_lookup(word_t addr);
		if (addr[31:8] == DATA_BASE[31:8])
			return dmem[addr[7:2]];
		return fill_word({addr[31:2], 2'b00});
	endfunction

	function automatic word_t lane_mask(logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	function automatic word_t decode_imm(word_t inst);
		case (inst[6:0])
			`RV_OP_STORE: return {{20{inst[31]}}, inst[31:25], inst[11:7]};
			`RV_OP_BRANCH: return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			`RV_OP_JAL: return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			`RV_OP_LUI, `RV_OP_AUIPC: return {inst[31:12], 12'b0};
			default: return {{20{inst[31]}}, inst[31:20]};
		endcase
	endfunction

	function automatic word_t alu_result(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic run_model();
		word_t pc;
		word_t inst;
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		word_t lane;
		word_t sdata;
		word_t next_pc;
		logic [3:0] strb;
		logic [2:0] f3;
		reg_idx_t rd;
		logic we;
		logic brk;
		logic taken;
		int steps;
		int n;
		for (n = 0; n < 32; n++)
			model_regs[n] = '0;
		pc = `RV_RESET_PC;
		brk = 1'b0;
		steps = 0;
		while (!brk && steps < 4 * PROG_LEN) begin
			inst = imem_lookup(pc);
			f3 = inst[14:12];
			rd = inst[11:7];
			a = model_regs[inst[19:15]];
			b = model_regs[inst[24:20]];
			res = '0;
			we = 1'b0;
			taken = 1'b0;
			next_pc = pc + 32'd4;
			case (inst[6:0])
				`RV_OP_IMM: begin
					res = alu_result(f3, (f3 == 3'b101) && inst[30], a, decode_imm(inst));
					we = 1'b1;
				end
				`RV_OP_REG: begin
					res = alu_result(f3, inst[30], a, b);
					we = 1'b1;
				end
				`RV_OP_LUI: begin
					res = decode_imm(inst);
					we = 1'b1;
				end
				`RV_OP_AUIPC: begin
					res = pc + decode_imm(inst);
					we = 1'b1;
				end
				`RV_OP_JAL: begin
					res = pc + 32'd4;
					next_pc = pc + decode_imm(inst);
					we = 1'b1;
				end
				`RV_OP_JALR: begin
					res = pc + 32'd4;
					next_pc = (a + decode_imm(inst)) & ~32'd1;
					we = 1'b1;
				end
				`RV_OP_BRANCH: begin
					case (f3)
						`RV_F3_BEQ: taken = (a == b);
						`RV_F3_BNE: taken = (a != b);
						`RV_F3_BLT: taken = ($signed(a) < $signed(b));
						`RV_F3_BGE: taken = ($signed(a) >= $signed(b));
						`RV_F3_BLTU: taken = (a < b);
						`RV_F3_BGEU: taken = (a >= b);
						default: taken = 1'b0;
					endcase
					if (taken)
						next_pc = pc + decode_imm(inst);
				end
				`RV_OP_LOAD: begin
					addr = a + decode_imm(inst);
					lane = model_mem[addr[7:2]] >> {addr[1:0], 3'b000};
					we = 1'b1;
					case (f3)
						`RV_F3_BYTE: res = {{24{lane[7]}}, lane[7:0]};
						`RV_F3_HALF: res = {{16{lane[15]}}, lane[15:0]};
						`RV_F3_BYTE_U: res = {24'b0, lane[7:0]};
						`RV_F3_HALF_U: res = {16'b0, lane[15:0]};
						default: res = lane;
					endcase
					ld_addr.push_back({addr[31:2], 2'b00});
				end
				`RV_OP_STORE: begin
					addr = a + decode_imm(inst);
					sdata = b << {addr[1:0], 3'b000};
					case (f3)
						`RV_F3_BYTE: strb = 4'b0001 << addr[1:0];
						`RV_F3_HALF: strb = 4'b0011 << addr[1:0];
						default: strb = 4'b1111;
					endcase
					for (n = 0; n < 4; n++)
						if (strb[n])
							model_mem[addr[7:2]][8 * n +: 8] = sdata[8 * n +: 8];
					st_addr.push_back({addr[31:2], 2'b00});
					st_strb.push_back(strb);
					st_data.push_back(sdata & lane_mask(strb));
				end
				`RV_OP_SYSTEM: brk = (inst == ebreak_word());
				default: begin
				end
			endcase
			exp_pc.push_back(pc);
			exp_we.push_back(we);
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			exp_brk.push_back(brk);
			if (we && rd != 5'd0)
				model_regs[rd] = res;
			pc = next_pc;
			steps++;
		end
		if (!brk)
			abort_run("The model never reached the EBREAK at the end of the program");
	endtask

	// ----------------------------------------------------------
	// Memory ports, retirement and store checks
	task automatic store_check();
		int n;
		if (st_count >= st_addr.size()) begin
			abort_run("The core wrote data memory with no store left in the program");
		end else begin
			check_value($sformatf("store %0d addr", st_count), st_addr[st_count], dmem_addr);
			check_value($sformatf("store %0d strobe", st_count), st_strb[st_count], dmem_wstrb);
			check_value($sformatf("store %0d data", st_count), st_data[st_count],
				dmem_wdata & lane_mask(dmem_wstrb));
			for (n = 0; n < 4; n++)
				if (dmem_wstrb[n])
					dmem[dmem_addr[7:2]][8 * n +: 8] = dmem_wdata[8 * n +: 8];
			st_count++;
		end
	endtask

	task automatic load_check();
		if (ld_count >= ld_addr.size()) begin
			abort_run("The core read data memory with no load left in the program");
		end else begin
			check_value($sformatf("load %0d addr", ld_count), ld_addr[ld_count], dmem_addr);
			ld_count++;
		end
	endtask

	task automatic retire_check();
		if (ret_count >= exp_pc.size()) begin
			abort_run("An instruction retired after the last one of the program");
		end else begin
			if (ret_count == 0)
				check_value("first retire pc", `RV_RESET_PC, retire.pc);
			check_value($sformatf("retire %0d pc", ret_count), exp_pc[ret_count], retire.pc);
			check_value($sformatf("retire %0d reg_write", ret_count), exp_we[ret_count],
				retire.reg_write);
			if (exp_we[ret_count]) begin
				check_value($sformatf("retire %0d rd", ret_count), exp_rd[ret_count], retire.rd);
				check_value($sformatf("retire %0d data", ret_count), exp_data[ret_count],
					retire.data);
			end
			check_value($sformatf("retire %0d ebreak", ret_count), exp_brk[ret_count],
				retire.is_ebreak);
			ret_count++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && dmem_write)
			store_check(); // Write lands before the read below
		if (rst_n && dmem_read)
			load_check();
		imem_data = imem_lookup(imem_addr);
		dmem_rdata = dmem_lookup(dmem_addr);
	end

	always @(negedge clk) begin
		if (retire_valid)
			retire_check();
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			abort_run("The run reached its cycle limit before the core halted");
	end

	// ----------------------------------------------------------
	// Main sequence
	initial begin
		int i;
		clk = 1'b0;
		rst_n = 1'b0;
		imem_data = '0;
		dmem_rdata = '0;
		rng_state = 32'hee82eca0;
		cycles = 0;
		ret_count = 0;
		st_count = 0;
		ld_count = 0;
		build_program();
		for (i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(DATA_BASE + 32'(4 * i));
			model_mem[i] = dmem[i];
		end
		run_model();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("reset retire_valid", 32'd0, retire_valid);
		check_value("reset halted", 32'd0, halted);
		check_value("reset dmem_write", 32'd0, dmem_write);
		check_value("reset dmem_read", 32'd0, dmem_read);
		check_value("reset pc", `RV_RESET_PC, imem_addr);
		while (!halted)
			@(negedge clk);
		check_value("retire count at halt", exp_pc.size(), ret_count);
		repeat (20) @(negedge clk); // Nothing may retire after EBREAK
		check_value("halted after EBREAK", 32'd1, halted);
		if (st_count != st_addr.size() || ld_count != ld_addr.size()) begin
			abort_run("The core skipped a load or store of the program");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- tb.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_regfile.sv
rv_core.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_memory.sv
  - rv_regfile.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
